//--- common/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;

	// All-zero word is sll $0,$0,0.
	localparam instr_t NOP_INSTR = 32'h0000_0000;

	// Primary opcodes.
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type function codes.
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [2:0] {
		K_NOP   = 3'd0,
		K_ALU_R = 3'd1,
		K_ALU_I = 3'd2,
		K_LUI   = 3'd3,
		K_LOAD  = 3'd4,
		K_STORE = 3'd5,
		K_BEQ   = 3'd6,
		K_JUMP  = 3'd7
	} instr_kind_t;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLT = 5'd4,
		ALU_LUI = 5'd5
	} alu_op_t;

	typedef enum logic [2:0] {
		EXT_ZERO  = 3'd0,
		EXT_SIGN  = 3'd1,
		EXT_UPPER = 3'd2
	} ext_mode_t;

	typedef enum logic [1:0] {
		FWD_RF = 2'd0, // Register file read.
		FWD_M  = 2'd1, // M-stage ALU result.
		FWD_W  = 2'd2  // W-stage write data.
	} fwd_sel_t;

	// Stage positions counted from D.
	localparam int STG_E = 1;
	localparam int STG_M = 2;

	// Stage where an operand is needed.
	localparam int T_USE_BRANCH = 0;
	localparam int T_USE_ALU    = 1;

	// Stage where a result becomes available for forwarding.
	localparam int T_NEW_ALU  = 2;
	localparam int T_NEW_LOAD = 3;

endpackage

//--- common/stage_if.sv
`timescale 1ns/1ps

// Register usage of the instruction held in one stage.
interface stage_if import mips_pkg::*; ();

	instr_kind_t kind;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic        uses_rs;
	logic        uses_rt;
	logic        wr_en;    // Never set for $0.
	reg_addr_t   wr_addr;

	modport src (
		output kind,
		output rs,
		output rt,
		output uses_rs,
		output uses_rt,
		output wr_en,
		output wr_addr
	);

	modport hz (
		input kind,
		input rs,
		input rt,
		input uses_rs,
		input uses_rt,
		input wr_en,
		input wr_addr
	);

endinterface

//--- control/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
	stage_if.hz      d,
	stage_if.hz      e,
	stage_if.hz      m,
	stage_if.hz      w,
	output logic     stall,
	output fwd_sel_t fwd_d1,
	output fwd_sel_t fwd_d2,
	output fwd_sel_t fwd_e1,
	output fwd_sel_t fwd_e2
);

	// Reader of r and writer of r meet. $0 never matches.
	function automatic logic src_hit(
		input reg_addr_t r,
		input logic      used,
		input logic      wr_en,
		input reg_addr_t wr_addr
	);
		return used && (r != '0) && wr_en && (wr_addr == r);
	endfunction

	function automatic int t_new(input instr_kind_t kind);
		return (kind == K_LOAD) ? T_NEW_LOAD : T_NEW_ALU;
	endfunction

	// Producer at stg cannot deliver before the reader needs it.
	function automatic logic too_late(
		input instr_kind_t kind,
		input int          stg,
		input int          use_stg
	);
		return (t_new(kind) - stg) > use_stg;
	endfunction

	function automatic fwd_sel_t pick_src(
		input reg_addr_t r,
		input logic      used,
		input logic      m_ready,
		input reg_addr_t m_addr,
		input logic      w_wr,
		input reg_addr_t w_addr
	);
		if (src_hit(r, used, m_ready, m_addr))
			return FWD_M; // Nearer stage first.
		if (src_hit(r, used, w_wr, w_addr))
			return FWD_W;
		return FWD_RF;
	endfunction

	int   d_use;
	logic e_hit;
	logic m_hit;
	logic m_ready;

	assign d_use = (d.kind == K_BEQ) ? T_USE_BRANCH : T_USE_ALU;

	assign e_hit = src_hit(d.rs, d.uses_rs, e.wr_en, e.wr_addr) ||
		src_hit(d.rt, d.uses_rt, e.wr_en, e.wr_addr);
	assign m_hit = src_hit(d.rs, d.uses_rs, m.wr_en, m.wr_addr) ||
		src_hit(d.rt, d.uses_rt, m.wr_en, m.wr_addr);

	// Covers load-use and both branch cases.
	assign stall = (e_hit && too_late(e.kind, STG_E, d_use)) ||
		(m_hit && too_late(m.kind, STG_M, d_use));

	// A load in M has no result yet.
	assign m_ready = m.wr_en && (t_new(m.kind) <= STG_M);

	assign fwd_d1 = pick_src(d.rs, d.uses_rs, m_ready, m.wr_addr, w.wr_en, w.wr_addr);
	assign fwd_d2 = pick_src(d.rt, d.uses_rt, m_ready, m.wr_addr, w.wr_en, w.wr_addr);
	assign fwd_e1 = pick_src(e.rs, e.uses_rs, m_ready, m.wr_addr, w.wr_en, w.wr_addr);
	assign fwd_e2 = pick_src(e.rt, e.uses_rt, m_ready, m.wr_addr, w.wr_en, w.wr_addr);

endmodule

//--- control/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import mips_pkg::*; (
	input  instr_t    instr,
	stage_if.src      info,
	output ext_mode_t ext_mode,
	output alu_op_t   alu_op,
	output logic      alu_num2_imm,
	output logic      dm_write_enable,
	output logic      rf_write_mem
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	reg_addr_t   rs_field;
	reg_addr_t   rt_field;
	reg_addr_t   rd_field;
	instr_kind_t kind;
	logic        uses_rs;
	logic        uses_rt;
	reg_addr_t   wr_addr;

	assign opcode   = instr[31:26];
	assign rs_field = instr[25:21];
	assign rt_field = instr[20:16];
	assign rd_field = instr[15:11];
	assign funct    = instr[5:0];

	always_comb begin
		kind   = K_NOP;
		alu_op = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				kind = K_ALU_R;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: kind = K_NOP; // Includes sll, so the zero word.
				endcase
			end
			OP_ADDIU: kind = K_ALU_I;
			OP_ORI: begin
				kind   = K_ALU_I;
				alu_op = ALU_OR;
			end
			OP_LUI: begin
				kind   = K_LUI;
				alu_op = ALU_LUI;
			end
			OP_LW:   kind = K_LOAD;
			OP_SW:   kind = K_STORE;
			OP_BEQ:  kind = K_BEQ;
			OP_J:    kind = K_JUMP; // No register traffic.
			default: kind = K_NOP;
		endcase
	end

	always_comb begin
		case (kind)
			K_ALU_I:                  ext_mode = (opcode == OP_ORI) ? EXT_ZERO : EXT_SIGN;
			K_LUI:                    ext_mode = EXT_UPPER;
			K_LOAD, K_STORE, K_BEQ:   ext_mode = EXT_SIGN;
			default:                  ext_mode = EXT_ZERO;
		endcase
	end

	// Destination register.
	always_comb begin
		case (kind)
			K_ALU_R:                  wr_addr = rd_field;
			K_ALU_I, K_LUI, K_LOAD:   wr_addr = rt_field;
			default:                  wr_addr = '0;
		endcase
	end

	assign uses_rs = kind inside {K_ALU_R, K_ALU_I, K_LOAD, K_STORE, K_BEQ};
	assign uses_rt = kind inside {K_ALU_R, K_STORE, K_BEQ};

	assign alu_num2_imm    = kind inside {K_ALU_I, K_LUI, K_LOAD, K_STORE};
	assign dm_write_enable = (kind == K_STORE);
	assign rf_write_mem    = (kind == K_LOAD);

	assign info.kind    = kind;
	assign info.uses_rs = uses_rs;
	assign info.uses_rt = uses_rt;
	assign info.rs      = uses_rs ? rs_field : '0; // Unused fields read as $0.
	assign info.rt      = uses_rt ? rt_field : '0;
	assign info.wr_addr = wr_addr;
	assign info.wr_en   = (wr_addr != '0);

endmodule

//--- control/mips_control.sv
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  instr_t    curr_instr,
	output logic      pc_enable,
	output logic      d_enable,
	output ext_mode_t d_ext_mode,
	output reg_addr_t d_rf_read_addr1,
	output reg_addr_t d_rf_read_addr2,
	output logic      e_alu_num2_imm,
	output alu_op_t   e_alu_op,
	output logic      m_dm_write_enable,
	output logic      w_rf_write_enable,
	output logic      w_rf_write_mem,
	output reg_addr_t w_rf_write_addr,
	output fwd_sel_t  fwd_d1,
	output fwd_sel_t  fwd_d2,
	output fwd_sel_t  fwd_e1,
	output fwd_sel_t  fwd_e2
);

	instr_t d_instr;
	instr_t e_instr;
	instr_t m_instr;
	instr_t w_instr;
	logic   stall;

	stage_if d_info();
	stage_if e_info();
	stage_if m_info();
	stage_if w_info();

	stage_pipe u_pipe (
		.clk        (clk),
		.reset      (reset),
		.curr_instr (curr_instr),
		.stall      (stall),
		.d_instr    (d_instr),
		.e_instr    (e_instr),
		.m_instr    (m_instr),
		.w_instr    (w_instr)
	);

	// Each stage keeps only its own controls.
	instr_decode u_dec_d (
		.instr           (d_instr),
		.info            (d_info),
		.ext_mode        (d_ext_mode),
		.alu_op          (),
		.alu_num2_imm    (),
		.dm_write_enable (),
		.rf_write_mem    ()
	);

	instr_decode u_dec_e (
		.instr           (e_instr),
		.info            (e_info),
		.ext_mode        (),
		.alu_op          (e_alu_op),
		.alu_num2_imm    (e_alu_num2_imm),
		.dm_write_enable (),
		.rf_write_mem    ()
	);

	instr_decode u_dec_m (
		.instr           (m_instr),
		.info            (m_info),
		.ext_mode        (),
		.alu_op          (),
		.alu_num2_imm    (),
		.dm_write_enable (m_dm_write_enable),
		.rf_write_mem    ()
	);

	instr_decode u_dec_w (
		.instr           (w_instr),
		.info            (w_info),
		.ext_mode        (),
		.alu_op          (),
		.alu_num2_imm    (),
		.dm_write_enable (),
		.rf_write_mem    (w_rf_write_mem)
	);

	hazard_unit u_hazard (
		.d      (d_info),
		.e      (e_info),
		.m      (m_info),
		.w      (w_info),
		.stall  (stall),
		.fwd_d1 (fwd_d1),
		.fwd_d2 (fwd_d2),
		.fwd_e1 (fwd_e1),
		.fwd_e2 (fwd_e2)
	);

	assign pc_enable = ~stall;
	assign d_enable  = ~stall; // Fetch register holds with the PC.

	assign d_rf_read_addr1   = d_info.rs;
	assign d_rf_read_addr2   = d_info.rt;
	assign w_rf_write_enable = w_info.wr_en;
	assign w_rf_write_addr   = w_info.wr_addr;

endmodule

//--- control/stage_pipe.sv
`timescale 1ns/1ps

module stage_pipe import mips_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  instr_t curr_instr,
	input  logic   stall,
	output instr_t d_instr,
	output instr_t e_instr,
	output instr_t m_instr,
	output instr_t w_instr
);

	always_ff @(posedge clk) begin
		if (reset) begin
			d_instr <= NOP_INSTR;
			e_instr <= NOP_INSTR;
			m_instr <= NOP_INSTR;
			w_instr <= NOP_INSTR;
		end else if (stall) begin
			// D waits, a bubble goes down the pipe.
			d_instr <= d_instr;
			e_instr <= NOP_INSTR;
			m_instr <= e_instr;
			w_instr <= m_instr;
		end else begin
			d_instr <= curr_instr;
			e_instr <= d_instr;
			m_instr <= e_instr;
			w_instr <= m_instr;
		end
	end

endmodule

//--- project.f
+incdir+tb
common/mips_pkg.sv
common/stage_if.sv
control/instr_decode.sv
control/stage_pipe.sv
control/hazard_unit.sv
control/mips_control.sv
tb/tb_mips_control.sv

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected controls of one instruction.
typedef struct packed {
	instr_kind_t kind;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic        uses_rs;
	logic        uses_rt;
	logic        wr_en;
	reg_addr_t   wr_addr;
	ext_mode_t   ext;
	alu_op_t     alu;
	logic        imm;
	logic        dm_we;
	logic        wb_mem;
} ref_ctrl_t;

function automatic ref_ctrl_t decode_ctrl(input instr_t ins);
	ref_ctrl_t  c;
	logic [5:0] op;
	logic [5:0] fn;
	op = ins[31:26];
	fn = ins[5:0];
	c  = '0; // Nop, add, zero extension.
	case (op)
		OP_RTYPE:
			c.kind = (fn inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT}) ?
				K_ALU_R : K_NOP;
		OP_ADDIU, OP_ORI: c.kind = K_ALU_I;
		OP_LUI:  c.kind = K_LUI;
		OP_LW:   c.kind = K_LOAD;
		OP_SW:   c.kind = K_STORE;
		OP_BEQ:  c.kind = K_BEQ;
		OP_J:    c.kind = K_JUMP;
		default: c.kind = K_NOP;
	endcase
	if (c.kind == K_ALU_R)
		c.alu = (fn == FN_SUBU) ? ALU_SUB : (fn == FN_AND) ? ALU_AND :
			(fn == FN_OR) ? ALU_OR : (fn == FN_SLT) ? ALU_SLT : ALU_ADD;
	else if (op == OP_ORI)
		c.alu = ALU_OR;
	else if (op == OP_LUI)
		c.alu = ALU_LUI;
	if (op == OP_LUI)
		c.ext = EXT_UPPER;
	else if (c.kind inside {K_ALU_I, K_LOAD, K_STORE, K_BEQ} && op != OP_ORI)
		c.ext = EXT_SIGN;
	c.uses_rs = c.kind inside {K_ALU_R, K_ALU_I, K_LOAD, K_STORE, K_BEQ};
	c.uses_rt = c.kind inside {K_ALU_R, K_STORE, K_BEQ};
	c.rs      = c.uses_rs ? ins[25:21] : 5'd0;
	c.rt      = c.uses_rt ? ins[20:16] : 5'd0;
	if (c.kind == K_ALU_R)
		c.wr_addr = ins[15:11];
	else if (c.kind inside {K_ALU_I, K_LUI, K_LOAD})
		c.wr_addr = ins[20:16];
	c.wr_en  = (c.wr_addr != 5'd0);
	c.imm    = c.kind inside {K_ALU_I, K_LUI, K_LOAD, K_STORE};
	c.dm_we  = (c.kind == K_STORE);
	c.wb_mem = (c.kind == K_LOAD);
	return c;
endfunction

function automatic logic reads_reg(input ref_ctrl_t c, input reg_addr_t r);
	return (r != 5'd0) && ((c.uses_rs && c.rs == r) || (c.uses_rt && c.rt == r));
endfunction

function automatic logic expect_stall(
	input ref_ctrl_t d,
	input ref_ctrl_t e,
	input ref_ctrl_t m
);
	logic branch;
	branch = (d.kind == K_BEQ);
	if (e.wr_en && reads_reg(d, e.wr_addr) && (e.kind == K_LOAD || branch))
		return 1'b1;
	if (branch && m.wr_en && m.kind == K_LOAD && reads_reg(d, m.wr_addr))
		return 1'b1; // Load data only in W.
	return 1'b0;
endfunction

function automatic fwd_sel_t pick_fwd(
	input reg_addr_t r,
	input logic      used,
	input ref_ctrl_t m,
	input ref_ctrl_t w
);
	if (!used || r == 5'd0)
		return FWD_RF;
	if (m.wr_en && m.kind != K_LOAD && m.wr_addr == r)
		return FWD_M;
	if (w.wr_en && w.wr_addr == r)
		return FWD_W;
	return FWD_RF;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

function automatic instr_t make_r(
	input logic [5:0] fn,
	input reg_addr_t  rd,
	input reg_addr_t  rs,
	input reg_addr_t  rt
);
	return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic instr_t make_i(
	input logic [5:0]  op,
	input reg_addr_t   rt,
	input reg_addr_t   rs,
	input logic [15:0] imm
);
	return {op, rs, rt, imm};
endfunction

// Registers 0 to 7 only, so hazards come often.
function automatic instr_t random_instr(input logic [31:0] r);
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [15:0] imm;
	rs  = {2'b00, r[2:0]};
	rt  = {2'b00, r[5:3]};
	rd  = {2'b00, r[8:6]};
	imm = r[24:9];
	case (r[31:25] % 13)
		0:       return make_r(FN_ADDU, rd, rs, rt);
		1:       return make_r(FN_SUBU, rd, rs, rt);
		2:       return make_r(FN_AND, rd, rs, rt);
		3:       return make_r(FN_OR, rd, rs, rt);
		4:       return make_r(FN_SLT, rd, rs, rt);
		5:       return make_i(OP_ADDIU, rt, rs, imm);
		6:       return make_i(OP_ORI, rt, rs, imm);
		7:       return make_i(OP_LUI, rt, 5'd0, imm);
		8:       return make_i(OP_LW, rt, rs, imm);
		9:       return make_i(OP_SW, rt, rs, imm);
		10:      return make_i(OP_BEQ, rt, rs, imm);
		11:      return {OP_J, r[25:0]};
		default: return NOP_INSTR;
	endcase
endfunction

`endif

//--- tb/tb_mips_control.sv
`timescale 1ns/1ps

module tb_mips_control import mips_pkg::*; ();

	`include "tb_ref_model.svh"

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 5;
	localparam int N_RANDOM        = 400;
	localparam int DRAIN_CYCLES    = 6;
	localparam int DIRECTED_STALLS = 4; // Load-use 1, beq after ALU 1, beq after lw 2.

	logic      clk;
	logic      reset;
	instr_t    curr_instr;
	logic      pc_enable;
	logic      d_enable;
	ext_mode_t d_ext_mode;
	reg_addr_t d_rf_read_addr1;
	reg_addr_t d_rf_read_addr2;
	logic      e_alu_num2_imm;
	alu_op_t   e_alu_op;
	logic      m_dm_write_enable;
	logic      w_rf_write_enable;
	logic      w_rf_write_mem;
	reg_addr_t w_rf_write_addr;
	fwd_sel_t  fwd_d1;
	fwd_sel_t  fwd_d2;
	fwd_sel_t  fwd_e1;
	fwd_sel_t  fwd_e2;

	instr_t      prog[$];
	instr_t      sh_d;
	instr_t      sh_e;
	instr_t      sh_m;
	instr_t      sh_w;
	ref_ctrl_t   exp_d;
	ref_ctrl_t   exp_e;
	ref_ctrl_t   exp_m;
	ref_ctrl_t   exp_w;
	logic        exp_stall;
	logic        sh_stall;
	logic        taken;     // Fetched word went into D.
	logic [31:0] rng;
	int          cycle;
	int          issued;
	int          n_directed;
	int          prog_len;
	int          stalls_directed;
	int          checks;
	int          errors;

	mips_control UUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_ext(input string name, input ext_mode_t exp, input ext_mode_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_alu(input string name, input alu_op_t exp, input alu_op_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_fwd(input string name, input fwd_sel_t exp, input fwd_sel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic push_instr(input instr_t ins, input int gap);
		prog.push_back(ins);
		repeat (gap) prog.push_back(NOP_INSTR);
	endtask

	task automatic load_directed();
		push_instr(make_r(FN_ADDU, 5'd3, 5'd1, 5'd2), 3); // Every kind once.
		push_instr(make_r(FN_SUBU, 5'd3, 5'd2, 5'd1), 3);
		push_instr(make_r(FN_AND, 5'd4, 5'd1, 5'd2), 3);
		push_instr(make_r(FN_OR, 5'd5, 5'd2, 5'd1), 3);
		push_instr(make_r(FN_SLT, 5'd6, 5'd1, 5'd2), 3);
		push_instr(make_i(OP_ADDIU, 5'd4, 5'd1, 16'hfffb), 3);
		push_instr(make_i(OP_ORI, 5'd5, 5'd2, 16'h8001), 3);
		push_instr(make_i(OP_LUI, 5'd7, 5'd0, 16'h1234), 3);
		push_instr(make_i(OP_LW, 5'd6, 5'd1, 16'h0004), 3);
		push_instr(make_i(OP_SW, 5'd6, 5'd2, 16'h0008), 3);
		push_instr(make_i(OP_BEQ, 5'd2, 5'd1, 16'h0010), 3);
		push_instr({OP_J, 26'h000_0040}, 3);
		push_instr(make_r(6'h08, 5'd3, 5'd1, 5'd0), 3); // Unsupported jr.
		push_instr({6'h3f, 26'h3ff_ffff}, 3);
		// Load-use.
		push_instr(make_i(OP_LW, 5'd2, 5'd1, 16'h0000), 0);
		push_instr(make_r(FN_ADDU, 5'd3, 5'd2, 5'd1), 4);
		// Branch on a fresh ALU result and then on a fresh load.
		push_instr(make_r(FN_ADDU, 5'd4, 5'd1, 5'd1), 0);
		push_instr(make_i(OP_BEQ, 5'd0, 5'd4, 16'h0008), 4);
		push_instr(make_i(OP_LW, 5'd5, 5'd1, 16'h0000), 0);
		push_instr(make_i(OP_BEQ, 5'd1, 5'd5, 16'h0008), 4);
		push_instr(make_r(FN_ADDU, 5'd0, 5'd1, 5'd2), 0); // Writes to $0.
		push_instr(make_i(OP_LW, 5'd0, 5'd1, 16'h0000), 0);
		push_instr(make_r(FN_OR, 5'd3, 5'd0, 5'd0), 1);
		// Two writers of $6 in flight.
		push_instr(make_r(FN_ADDU, 5'd6, 5'd1, 5'd1), 0);
		push_instr(make_r(FN_ADDU, 5'd6, 5'd2, 5'd2), 0);
		push_instr(make_r(FN_ADDU, 5'd7, 5'd6, 5'd6), 4);
	endtask

	task automatic load_random();
		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift32(rng);
			prog.push_back(random_instr(rng));
		end
	endtask

	// Shadow pipeline.
	always @(posedge clk) begin
		cycle++;
		if (reset) begin
			sh_d  = NOP_INSTR;
			sh_e  = NOP_INSTR;
			sh_m  = NOP_INSTR;
			sh_w  = NOP_INSTR;
			taken = 1'b1;
		end else begin
			if (!pc_enable && issued <= n_directed)
				stalls_directed++; // DUT stall seen before the edge takes effect.
			sh_stall = expect_stall(decode_ctrl(sh_d), decode_ctrl(sh_e), decode_ctrl(sh_m));
			taken = !sh_stall;
			sh_w  = sh_m;
			sh_m  = sh_e;
			sh_e  = sh_stall ? NOP_INSTR : sh_d; // Bubble.
			if (!sh_stall)
				sh_d = curr_instr;
		end
	end

	always @(negedge clk) begin
		if (cycle > 0) begin
			exp_d     = decode_ctrl(sh_d);
			exp_e     = decode_ctrl(sh_e);
			exp_m     = decode_ctrl(sh_m);
			exp_w     = decode_ctrl(sh_w);
			exp_stall = expect_stall(exp_d, exp_e, exp_m);
			check_bit("pc_enable", !exp_stall, pc_enable);
			check_bit("d_enable", !exp_stall, d_enable);
			check_ext("d_ext_mode", exp_d.ext, d_ext_mode);
			check_addr("d_rf_read_addr1", exp_d.rs, d_rf_read_addr1);
			check_addr("d_rf_read_addr2", exp_d.rt, d_rf_read_addr2);
			check_bit("e_alu_num2_imm", exp_e.imm, e_alu_num2_imm);
			check_alu("e_alu_op", exp_e.alu, e_alu_op);
			check_bit("m_dm_write_enable", exp_m.dm_we, m_dm_write_enable);
			check_bit("w_rf_write_enable", exp_w.wr_en, w_rf_write_enable);
			check_bit("w_rf_write_mem", exp_w.wb_mem, w_rf_write_mem);
			check_addr("w_rf_write_addr", exp_w.wr_addr, w_rf_write_addr);
			check_fwd("fwd_d1", pick_fwd(exp_d.rs, exp_d.uses_rs, exp_m, exp_w), fwd_d1);
			check_fwd("fwd_d2", pick_fwd(exp_d.rt, exp_d.uses_rt, exp_m, exp_w), fwd_d2);
			check_fwd("fwd_e1", pick_fwd(exp_e.rs, exp_e.uses_rs, exp_m, exp_w), fwd_e1);
			check_fwd("fwd_e2", pick_fwd(exp_e.rt, exp_e.uses_rt, exp_m, exp_w), fwd_e2);
		end
	end

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		curr_instr = NOP_INSTR;
		rng        = 32'd29255;
		load_directed();
		n_directed = prog.size();
		load_random();
		prog_len = prog.size();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (prog.size() > 0) begin
			if (taken) begin
				curr_instr = prog.pop_front();
				issued++;
			end
			@(negedge clk);
		end
		while (!taken)
			@(negedge clk);
		curr_instr = NOP_INSTR;
		repeat (DRAIN_CYCLES) @(negedge clk);
		@(posedge clk);
		if (stalls_directed != DIRECTED_STALLS) begin
			errors++;
			$display("Directed hazard tests stalled %0d cycles instead of %0d",
				stalls_directed, DIRECTED_STALLS);
		end
		$display("Summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// At most two stall cycles per instruction.
	initial begin
		wait (prog_len > 0);
		#((RESET_CYCLES + 3 * prog_len + DRAIN_CYCLES + 20) * CLK_PERIOD);
		$display("Timeout: the run did not finish, %0d of %0d instructions issued",
			issued, prog_len);
		$display("Regression failed");
		$finish;
	end

endmodule
